/* common/secv_defines.svh */
// Global width and alignment constants for the execute stage
`ifndef SECV_DEFINES_SVH
`define SECV_DEFINES_SVH

// Data and address width
`define SECV_XLEN 32

// Instruction length in bytes
// Also the step from pc to the return address
`define SECV_ILEN_BYTES 4

// Low target bits that must be zero on a redirect
`define SECV_ALIGN_BITS 2

`endif

/* common/secv_isa_pkg.sv */
// ISA level types: unit select, branch and ALU opcodes, shared op field
package secv_isa_pkg;

    // Function unit selected at issue
    // Code 2'b11 is not named and is handled like UNIT_NONE
    typedef enum logic [1:0] {
        UNIT_ALU    = 2'b00,
        UNIT_BRANCH = 2'b01,
        UNIT_NONE   = 2'b10
    } unit_sel_t;

    // Branch opcodes, laid out like funct3
    // Jumps sit in the two funct3 slots that branches leave free
    typedef enum logic [2:0] {
        BRANCH_OP_BEQ  = 3'b000,
        BRANCH_OP_BNE  = 3'b001,
        BRANCH_OP_JAL  = 3'b010,
        BRANCH_OP_JALR = 3'b011,
        BRANCH_OP_BLT  = 3'b100,
        BRANCH_OP_BGE  = 3'b101,
        BRANCH_OP_BLTU = 3'b110,
        BRANCH_OP_BGEU = 3'b111
    } branch_op_t;

    // Branch view of the 4-bit op field
    // A set rsvd bit marks an unused branch code
    typedef struct packed {
        logic       rsvd;
        branch_op_t op;
    } funit_branch_op_t;

    // ALU opcodes as {funct7[5], funct3}
    typedef enum logic [3:0] {
        ALU_OP_ADD  = 4'b0000,
        ALU_OP_SLL  = 4'b0001,
        ALU_OP_SLT  = 4'b0010,
        ALU_OP_SLTU = 4'b0011,
        ALU_OP_XOR  = 4'b0100,
        ALU_OP_SRL  = 4'b0101,
        ALU_OP_OR   = 4'b0110,
        ALU_OP_AND  = 4'b0111,
        ALU_OP_SUB  = 4'b1000,
        ALU_OP_SRA  = 4'b1101
    } alu_op_t;

    // One op field, read by each unit in its own format
    typedef union packed {
        alu_op_t          alu;
        funit_branch_op_t branch;
    } funit_op_t;

endpackage

/* common/secv_funit_pkg.sv */
// Function unit result type and its idle value
`include "secv_defines.svh"

package secv_funit_pkg;

    // Result of one function unit for one issue
    typedef struct packed {
        // Unit was enabled and result is valid
        logic                  rdy;
        // Illegal op or misaligned redirect
        logic                  err;
        // Next pc on a redirect
        logic [`SECV_XLEN-1:0] pc;
        logic                  pc_wb;
        // Destination register data
        logic [`SECV_XLEN-1:0] rd_dat;
        logic                  rd_wb;
    } funit_out_t;

    // Idle result, all fields zero
    function automatic funit_out_t funit_out_default();
        funit_out_t res;
        res.rdy    = 1'b0;
        res.err    = 1'b0;
        res.pc     = '0;
        res.pc_wb  = 1'b0;
        res.rd_dat = '0;
        res.rd_wb  = 1'b0;
        return res;
    endfunction

    // Invalid-issue result
    // Error without any writeback
    function automatic funit_out_t funit_out_error();
        funit_out_t res;
        res     = funit_out_default();
        res.rdy = 1'b1;
        res.err = 1'b1;
        return res;
    endfunction

endpackage

/* common/funit_if.sv */
// Link between the execute stage and one combinational function unit
`timescale 1ns/1ns
`include "secv_defines.svh"

interface funit_if
    import secv_isa_pkg::*;
    import secv_funit_pkg::*;
();

    // Stage to unit
    logic                  ena;
    funit_op_t             op;
    logic [`SECV_XLEN-1:0] a;
    logic [`SECV_XLEN-1:0] b;
    logic [`SECV_XLEN-1:0] imm;
    logic [`SECV_XLEN-1:0] pc;

    // Unit to stage, same cycle as ena
    funit_out_t            res;

    // Function unit side
    modport unit (
        input  ena, op, a, b, imm, pc,
        output res
    );

    // Execute stage side
    modport stage (
        output ena, op, a, b, imm, pc,
        input  res
    );

endinterface

/* hw/funit/branch_unit.sv */
// Branch unit: branch and jump decision, target, link address and misalignment check
`timescale 1ns/1ns
`include "secv_defines.svh"

module branch_unit
    import secv_isa_pkg::*;
    import secv_funit_pkg::*;
(
    funit_if.unit fu
);

    localparam int XLEN = `SECV_XLEN;
    localparam int ALIGN_BITS = `SECV_ALIGN_BITS;

    // Op field in branch format
    branch_op_t      op;
    logic            op_rsvd;

    // Address paths
    logic [XLEN-1:0] jalr_sum;
    logic [XLEN-1:0] target;
    logic [XLEN-1:0] pc_ret;

    // Decision flags
    logic            taken;
    logic            link;
    logic            misalign;
    logic            err;

    assign op      = fu.op.branch.op;
    assign op_rsvd = fu.op.branch.rsvd;

    // Register-relative base for JALR
    assign jalr_sum = fu.a + fu.imm;

    always_comb begin
        // JALR drops bit 0 of the sum
        if (op == BRANCH_OP_JALR) begin
            target = {jalr_sum[XLEN-1:1], 1'b0};
        end else begin
            // Pc-relative for branches and JAL
            target = fu.pc + fu.imm;
        end
    end

    // Link address, next sequential instruction
    assign pc_ret = fu.pc + XLEN'(`SECV_ILEN_BYTES);

    always_comb begin
        taken = 1'b0;
        link  = 1'b0;

        case (op)
            BRANCH_OP_BEQ:  taken = (fu.a == fu.b);
            BRANCH_OP_BNE:  taken = (fu.a != fu.b);
            BRANCH_OP_BLT:  taken = ($signed(fu.a) <  $signed(fu.b));
            BRANCH_OP_BGE:  taken = ($signed(fu.a) >= $signed(fu.b));
            BRANCH_OP_BLTU: taken = (fu.a <  fu.b);
            BRANCH_OP_BGEU: taken = (fu.a >= fu.b);
            // Jumps always redirect and link
            BRANCH_OP_JAL,
            BRANCH_OP_JALR: begin
                taken = 1'b1;
                link  = 1'b1;
            end
            default: begin
                taken = 1'b0;
                link  = 1'b0;
            end
        endcase
    end

    // Only a taken redirect is checked for alignment
    assign misalign = |target[ALIGN_BITS-1:0];
    assign err      = op_rsvd | (taken & misalign);

    always_comb begin
        fu.res = funit_out_default();

        if (fu.ena) begin
            fu.res.rdy    = 1'b1;
            fu.res.err    = err;
            // Target reported even when not taken
            fu.res.pc     = target;
            fu.res.pc_wb  = taken & ~err;
            // Link data goes out with every branch op
            fu.res.rd_dat = pc_ret;
            fu.res.rd_wb  = link & ~err;
        end
    end

endmodule

/* hw/funit/alu_unit.sv */
// Integer ALU: add, subtract, logic, set-less-than and shift operations
`timescale 1ns/1ns
`include "secv_defines.svh"

module alu_unit
    import secv_isa_pkg::*;
    import secv_funit_pkg::*;
(
    funit_if.unit fu
);

    localparam int XLEN = `SECV_XLEN;
    localparam int SHAMT_W = $clog2(XLEN);

    // Op field in ALU format
    alu_op_t            op;

    // Shift amount, upper bits of b ignored
    logic [SHAMT_W-1:0] shamt;

    logic [XLEN-1:0]    result;
    logic               illegal;

    // Compare results
    logic               lt_s;
    logic               lt_u;

    assign op    = fu.op.alu;
    assign shamt = fu.b[SHAMT_W-1:0];

    assign lt_s = $signed(fu.a) < $signed(fu.b);
    assign lt_u = fu.a < fu.b;

    always_comb begin
        result  = '0;
        illegal = 1'b0;

        case (op)
            // Arithmetic wraps modulo 2^XLEN
            ALU_OP_ADD:  result = fu.a + fu.b;
            ALU_OP_SUB:  result = fu.a - fu.b;
            // Set less than, 0 or 1
            ALU_OP_SLT:  result = {{(XLEN-1){1'b0}}, lt_s};
            ALU_OP_SLTU: result = {{(XLEN-1){1'b0}}, lt_u};
            // Bitwise logic
            ALU_OP_XOR:  result = fu.a ^ fu.b;
            ALU_OP_OR:   result = fu.a | fu.b;
            ALU_OP_AND:  result = fu.a & fu.b;
            // Shifts
            ALU_OP_SLL:  result = fu.a << shamt;
            ALU_OP_SRL:  result = fu.a >> shamt;
            // Sign bit fills from the left
            ALU_OP_SRA:  result = $unsigned($signed(fu.a) >>> shamt);
            // Six free codes in the 4-bit field
            default: begin
                result  = '0;
                illegal = 1'b1;
            end
        endcase
    end

    always_comb begin
        fu.res = funit_out_default();

        if (fu.ena) begin
            fu.res.rdy    = 1'b1;
            fu.res.err    = illegal;
            // Instruction pc for tracing, never a redirect
            fu.res.pc     = fu.pc;
            fu.res.pc_wb  = 1'b0;
            fu.res.rd_dat = result;
            // No writeback on an illegal op
            fu.res.rd_wb  = ~illegal;
        end
    end

endmodule

/* hw/exec_stage.sv */
// Execute stage: routes an issue to one unit, merges its result and registers it
`timescale 1ns/1ns
`include "secv_defines.svh"

module exec_stage
    import secv_isa_pkg::*;
    import secv_funit_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  arst_n_i,

    // Decoded issue
    input  logic                  issue_valid_i,
    input  unit_sel_t             issue_unit_i,
    input  funit_op_t             issue_op_i,
    input  logic                  issue_use_imm_i,
    input  logic [`SECV_XLEN-1:0] rs1_i,
    input  logic [`SECV_XLEN-1:0] rs2_i,
    input  logic [`SECV_XLEN-1:0] imm_i,
    input  logic [`SECV_XLEN-1:0] pc_i,

    // Function units
    funit_if.stage                alu_fu,
    funit_if.stage                br_fu,

    // Registered result
    output logic                  res_valid_o,
    output logic                  res_err_o,
    output logic [`SECV_XLEN-1:0] rd_dat_o,
    output logic                  rd_wb_o,
    output logic [`SECV_XLEN-1:0] pc_o,
    output logic                  pc_wb_o
);

    localparam int XLEN = `SECV_XLEN;

    // Merged combinational result
    funit_out_t      merged;

    // Control part of the output register
    logic            res_valid_q;
    logic            res_err_q;
    logic            rd_wb_q;
    logic            pc_wb_q;

    // Payload part
    logic [XLEN-1:0] rd_dat_q;
    logic [XLEN-1:0] pc_q;

    // Only the selected unit sees ena
    assign alu_fu.ena = issue_valid_i && (issue_unit_i == UNIT_ALU);
    assign br_fu.ena  = issue_valid_i && (issue_unit_i == UNIT_BRANCH);

    // Shared operands
    assign alu_fu.op  = issue_op_i;
    assign alu_fu.a   = rs1_i;
    assign alu_fu.imm = imm_i;
    assign alu_fu.pc  = pc_i;

    // ALU second operand, register or immediate
    assign alu_fu.b   = issue_use_imm_i ? imm_i : rs2_i;

    // Branch compares rs1 with rs2, immediate is the offset
    assign br_fu.op   = issue_op_i;
    assign br_fu.a    = rs1_i;
    assign br_fu.b    = rs2_i;
    assign br_fu.imm  = imm_i;
    assign br_fu.pc   = pc_i;

    always_comb begin
        merged = funit_out_default();

        if (issue_valid_i) begin
            case (issue_unit_i)
                UNIT_ALU:    merged = alu_fu.res;
                UNIT_BRANCH: merged = br_fu.res;
                // UNIT_NONE and the unnamed code
                default:     merged = funit_out_error();
            endcase
        end
    end

    // Flags cleared on reset
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            res_valid_q <= 1'b0;
            res_err_q   <= 1'b0;
            rd_wb_q     <= 1'b0;
            pc_wb_q     <= 1'b0;
        end else begin
            // Idle cycles load the zero result
            res_valid_q <= merged.rdy;
            res_err_q   <= merged.err;
            rd_wb_q     <= merged.rd_wb;
            pc_wb_q     <= merged.pc_wb;
        end
    end

    // Data qualified by the flags above
    always_ff @(posedge clk_i) begin
        rd_dat_q <= merged.rd_dat;
        pc_q     <= merged.pc;
    end

    assign res_valid_o = res_valid_q;
    assign res_err_o   = res_err_q;
    assign rd_dat_o    = rd_dat_q;
    assign rd_wb_o     = rd_wb_q;
    assign pc_o        = pc_q;
    assign pc_wb_o     = pc_wb_q;

endmodule

/* hw/secv_exec_top.sv */
// Execute stage top level with the branch unit and the integer ALU
`timescale 1ns/1ns
`include "secv_defines.svh"

module secv_exec_top
    import secv_isa_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  arst_n_i,

    // Issue port
    input  logic                  issue_valid_i,
    input  unit_sel_t             issue_unit_i,
    input  funit_op_t             issue_op_i,
    input  logic                  issue_use_imm_i,
    input  logic [`SECV_XLEN-1:0] rs1_i,
    input  logic [`SECV_XLEN-1:0] rs2_i,
    input  logic [`SECV_XLEN-1:0] imm_i,
    input  logic [`SECV_XLEN-1:0] pc_i,

    // Result port, one cycle after issue
    output logic                  res_valid_o,
    output logic                  res_err_o,
    output logic [`SECV_XLEN-1:0] rd_dat_o,
    output logic                  rd_wb_o,
    output logic [`SECV_XLEN-1:0] pc_o,
    output logic                  pc_wb_o
);

    // One link per function unit
    funit_if alu_fu ();
    funit_if br_fu ();

    exec_stage u_exec (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .issue_valid_i   (issue_valid_i),
        .issue_unit_i    (issue_unit_i),
        .issue_op_i      (issue_op_i),
        .issue_use_imm_i (issue_use_imm_i),
        .rs1_i           (rs1_i),
        .rs2_i           (rs2_i),
        .imm_i           (imm_i),
        .pc_i            (pc_i),
        .alu_fu          (alu_fu.stage),
        .br_fu           (br_fu.stage),
        .res_valid_o     (res_valid_o),
        .res_err_o       (res_err_o),
        .rd_dat_o        (rd_dat_o),
        .rd_wb_o         (rd_wb_o),
        .pc_o            (pc_o),
        .pc_wb_o         (pc_wb_o)
    );

    // Combinational units
    branch_unit u_branch (
        .fu (br_fu.unit)
    );

    alu_unit u_alu (
        .fu (alu_fu.unit)
    );

endmodule

/* verification/tb_secv_exec.sv */
// Self-checking testbench for the execute stage with reference model and random issue
`timescale 1ns/1ns
`include "secv_defines.svh"

module tb_secv_exec
    import secv_isa_pkg::*;
    import secv_funit_pkg::*;
();

    localparam int XLEN = `SECV_XLEN;
    localparam int WAIT_LIMIT = 20;

    logic            clk = 1'b0;
    logic            arst_n;
    logic            issue_valid;
    unit_sel_t       issue_unit;
    funit_op_t       issue_op;
    logic            issue_use_imm;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] pc;
    logic            res_valid;
    logic            res_err;
    logic [XLEN-1:0] rd_dat;
    logic            rd_wb;
    logic [XLEN-1:0] pc_out;
    logic            pc_wb;

    // One expectation per driven cycle including idle ones
    funit_out_t      exp_q[$];
    string           name_q[$];
    funit_out_t      pend;
    string           pend_name;
    logic            have_pend = 1'b0;
    int              n_pushed = 0;
    int              n_checked = 0;
    logic [31:0]     rng = 32'h5628;

    secv_exec_top UUT (
        .clk_i           (clk),
        .arst_n_i        (arst_n),
        .issue_valid_i   (issue_valid),
        .issue_unit_i    (issue_unit),
        .issue_op_i      (issue_op),
        .issue_use_imm_i (issue_use_imm),
        .rs1_i           (rs1),
        .rs2_i           (rs2),
        .imm_i           (imm),
        .pc_i            (pc),
        .res_valid_o     (res_valid),
        .res_err_o       (res_err),
        .rd_dat_o        (rd_dat),
        .rd_wb_o         (rd_wb),
        .pc_o            (pc_out),
        .pc_wb_o         (pc_wb)
    );

    // 8 ns clock
    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // Expected registered result for one issue
    function automatic funit_out_t ref_exec(input logic valid, input unit_sel_t unit,
            input funit_op_t op, input logic use_imm, input logic [XLEN-1:0] a,
            input logic [XLEN-1:0] b, input logic [XLEN-1:0] i, input logic [XLEN-1:0] p);
        funit_out_t      r;
        logic [XLEN-1:0] opb;
        logic [XLEN-1:0] tgt;
        logic [XLEN-1:0] flip;
        logic [4:0]      sh;
        logic            taken;
        logic            jump;
        logic            bad;
        r     = '0;
        opb   = use_imm ? i : b;
        sh    = opb[4:0];
        // Signed compare done as unsigned with sign bits flipped
        flip  = {1'b1, {(XLEN-1){1'b0}}};
        taken = 1'b0;
        jump  = 1'b0;
        if (valid && unit == UNIT_ALU) begin
            r.rdy   = 1'b1;
            r.pc    = p;
            r.rd_wb = 1'b1;
            case (op.alu)
                ALU_OP_ADD:  r.rd_dat = a + opb;
                ALU_OP_SUB:  r.rd_dat = a - opb;
                ALU_OP_SLL:  r.rd_dat = a << sh;
                ALU_OP_SRL:  r.rd_dat = a >> sh;
                ALU_OP_SRA:  r.rd_dat = (a >> sh) | (a[XLEN-1] ? ~({XLEN{1'b1}} >> sh) : '0);
                ALU_OP_SLT:  r.rd_dat = {{(XLEN-1){1'b0}}, (a ^ flip) < (opb ^ flip)};
                ALU_OP_SLTU: r.rd_dat = {{(XLEN-1){1'b0}}, a < opb};
                ALU_OP_XOR:  r.rd_dat = a ^ opb;
                ALU_OP_OR:   r.rd_dat = a | opb;
                ALU_OP_AND:  r.rd_dat = a & opb;
                default: begin
                    r.err   = 1'b1;
                    r.rd_wb = 1'b0;
                end
            endcase
        end else if (valid && unit == UNIT_BRANCH) begin
            // JALR target is register based with bit 0 cleared
            if (op.branch.op == BRANCH_OP_JALR) begin
                tgt = (a + i) & ~{{(XLEN-1){1'b0}}, 1'b1};
            end else begin
                tgt = p + i;
            end
            case (op.branch.op)
                BRANCH_OP_BEQ:  taken = (a == b);
                BRANCH_OP_BNE:  taken = (a != b);
                BRANCH_OP_BLT:  taken = (a ^ flip) < (b ^ flip);
                BRANCH_OP_BGE:  taken = !((a ^ flip) < (b ^ flip));
                BRANCH_OP_BLTU: taken = (a < b);
                BRANCH_OP_BGEU: taken = !(a < b);
                default: begin
                    taken = 1'b1;
                    jump  = 1'b1;
                end
            endcase
            bad      = op.branch.rsvd || (taken && tgt[`SECV_ALIGN_BITS-1:0] != '0);
            r.rdy    = 1'b1;
            r.err    = bad;
            r.pc     = tgt;
            r.pc_wb  = taken && !bad;
            r.rd_dat = p + XLEN'(`SECV_ILEN_BYTES);
            r.rd_wb  = jump && !bad;
        end else if (valid) begin
            // No unit selected
            r.rdy = 1'b1;
            r.err = 1'b1;
        end
        return r;
    endfunction

    function automatic funit_op_t alu_code(input alu_op_t o);
        funit_op_t f;
        f.alu = o;
        return f;
    endfunction

    function automatic funit_op_t branch_code(input logic rsvd, input branch_op_t o);
        funit_op_t f;
        f.branch.rsvd = rsvd;
        f.branch.op   = o;
        return f;
    endfunction

    task automatic check_flag(input string test, input string field, input logic exp_val,
            input logic act_val);
        assert (act_val === exp_val) else begin
            $display("** Error [%s] %s expected %b, actual %b", test, field, exp_val, act_val);
            $display("Testbench failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic check_word(input string test, input string field,
            input logic [XLEN-1:0] exp_val, input logic [XLEN-1:0] act_val);
        assert (act_val === exp_val) else begin
            $display("** Error [%s] %s expected %h, actual %h", test, field, exp_val, act_val);
            $display("Testbench failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // All result flags low while no result may appear
    task automatic check_quiet(input string test);
        check_flag(test, "res_valid_o", 1'b0, res_valid);
        check_flag(test, "res_err_o", 1'b0, res_err);
        check_flag(test, "rd_wb_o", 1'b0, rd_wb);
        check_flag(test, "pc_wb_o", 1'b0, pc_wb);
    endtask

    task automatic abort_run(input string why);
        $display("Run aborted: %s", why);
        $display("Testbench failed");
        $fatal(1, "timeout");
    endtask

    // One issue on the next falling edge
    task automatic drive_issue(input string name, input unit_sel_t unit, input funit_op_t op,
            input logic use_imm, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
            input logic [XLEN-1:0] i, input logic [XLEN-1:0] p);
        @(negedge clk);
        issue_valid   = 1'b1;
        issue_unit    = unit;
        issue_op      = op;
        issue_use_imm = use_imm;
        rs1           = a;
        rs2           = b;
        imm           = i;
        pc            = p;
        exp_q.push_back(ref_exec(1'b1, unit, op, use_imm, a, b, i, p));
        name_q.push_back(name);
        n_pushed++;
    endtask

    task automatic drive_idle(input string name);
        @(negedge clk);
        issue_valid = 1'b0;
        exp_q.push_back(ref_exec(1'b0, UNIT_NONE, issue_op, 1'b0, '0, '0, '0, '0));
        name_q.push_back(name);
        n_pushed++;
    endtask

    // Cycles from issue to res_valid
    task automatic wait_result(output int lat);
        lat = 0;
        do begin
            drive_idle("latency");
            lat++;
        end while (!res_valid && lat < WAIT_LIMIT);
        if (!res_valid) begin
            abort_run("no result after a single issue");
        end
    endtask

    // Outputs before the edge belong to the issue of the previous edge
    always @(posedge clk) begin
        if (arst_n && have_pend) begin
            check_flag(pend_name, "res_valid_o", pend.rdy, res_valid);
            check_flag(pend_name, "res_err_o", pend.err, res_err);
            check_flag(pend_name, "rd_wb_o", pend.rd_wb, rd_wb);
            check_flag(pend_name, "pc_wb_o", pend.pc_wb, pc_wb);
            if (pend.rdy) begin
                check_word(pend_name, "rd_dat_o", pend.rd_dat, rd_dat);
                check_word(pend_name, "pc_o", pend.pc, pc_out);
            end
            n_checked++;
        end
        if (arst_n && exp_q.size() != 0) begin
            pend      = exp_q.pop_front();
            pend_name = name_q.pop_front();
            have_pend = 1'b1;
        end else begin
            have_pend = 1'b0;
        end
    end

    initial begin
        branch_op_t  conds [6] = '{BRANCH_OP_BEQ, BRANCH_OP_BNE, BRANCH_OP_BLT,
                                   BRANCH_OP_BGE, BRANCH_OP_BLTU, BRANCH_OP_BGEU};
        logic [31:0] cmp_a [5] = '{32'h0000_0005, 32'h8000_0000, 32'h0000_0001,
                                   32'hffff_ffff, 32'h0000_0000};
        logic [31:0] cmp_b [5] = '{32'h0000_0005, 32'h0000_0001, 32'h8000_0000,
                                   32'h0000_0000, 32'hffff_ffff};
        alu_op_t     alu_ops [10] = '{ALU_OP_ADD, ALU_OP_SUB, ALU_OP_SLL, ALU_OP_SLT,
                                      ALU_OP_SLTU, ALU_OP_XOR, ALU_OP_SRL, ALU_OP_SRA,
                                      ALU_OP_OR, ALU_OP_AND};
        // Shift amounts 1, 33, 4 and 31 in the low bits of b
        logic [31:0] alu_a [4] = '{32'h7fff_ffff, 32'h8000_0000, 32'hffff_fff0, 32'h0000_0005};
        logic [31:0] alu_b [4] = '{32'h0000_0001, 32'h0000_0021, 32'h0000_0004, 32'hffff_ffff};
        logic [31:0] rnd;
        logic [31:0] a;
        int          lat;
        int          n;
        arst_n        = 1'b0;
        // Issues held during reset must not reach the outputs
        issue_valid   = 1'b1;
        issue_unit    = UNIT_NONE;
        issue_op      = alu_code(ALU_OP_ADD);
        issue_use_imm = 1'b0;
        rs1           = '0;
        rs2           = '0;
        imm           = '0;
        pc            = '0;
        @(negedge clk);
        check_quiet("reset_hold_none");
        issue_unit = UNIT_BRANCH;
        issue_op   = branch_code(1'b0, BRANCH_OP_JAL);
        imm        = 32'h0000_0100;
        @(negedge clk);
        check_quiet("reset_hold_jal");
        issue_valid = 1'b0;
        issue_unit  = UNIT_NONE;
        issue_op    = alu_code(ALU_OP_ADD);
        imm         = '0;
        arst_n      = 1'b1;

        // Quiet outputs then one issue with fixed latency
        repeat (4) drive_idle("reset_idle");
        drive_issue("reset_latency", UNIT_ALU, alu_code(ALU_OP_ADD), 1'b0,
                    32'd3, 32'd4, 32'd0, 32'h100);
        wait_result(lat);
        check_word("reset_latency", "latency cycles", 32'd1, lat);

        // Conditional branches with forward and backward offsets
        for (int c = 0; c < 6; c++) begin
            for (int k = 0; k < 5; k++) begin
                drive_issue($sformatf("cond_%s", conds[c].name()), UNIT_BRANCH,
                            branch_code(1'b0, conds[c]), 1'b0, cmp_a[k], cmp_b[k],
                            k[0] ? 32'hffff_fff0 : 32'h0000_0040, 32'h0000_1000);
            end
        end

        // Jumps, misaligned targets and a reserved code
        drive_issue("jal", UNIT_BRANCH, branch_code(1'b0, BRANCH_OP_JAL), 1'b0,
                    32'h0, 32'h0, 32'h0000_0100, 32'h0000_2000);
        drive_issue("jal_back", UNIT_BRANCH, branch_code(1'b0, BRANCH_OP_JAL), 1'b0,
                    32'h0, 32'h0, 32'hffff_ff00, 32'h0000_2000);
        drive_issue("jalr_bit0", UNIT_BRANCH, branch_code(1'b0, BRANCH_OP_JALR), 1'b0,
                    32'h0000_3001, 32'h0, 32'h0000_0014, 32'h0000_2000);
        drive_issue("jalr_misalign", UNIT_BRANCH, branch_code(1'b0, BRANCH_OP_JALR), 1'b0,
                    32'h0000_3003, 32'h0, 32'h0000_0000, 32'h0000_2000);
        drive_issue("jal_misalign", UNIT_BRANCH, branch_code(1'b0, BRANCH_OP_JAL), 1'b0,
                    32'h0, 32'h0, 32'h0000_0102, 32'h0000_2000);
        drive_issue("beq_misalign", UNIT_BRANCH, branch_code(1'b0, BRANCH_OP_BEQ), 1'b0,
                    32'h7, 32'h7, 32'h0000_0006, 32'h0000_2000);
        drive_issue("branch_rsvd", UNIT_BRANCH, branch_code(1'b1, BRANCH_OP_JAL), 1'b0,
                    32'h0, 32'h0, 32'h0000_0100, 32'h0000_2000);

        // Every ALU op with a register and an immediate operand
        for (int o = 0; o < 10; o++) begin
            for (int k = 0; k < 4; k++) begin
                drive_issue($sformatf("alu_reg_%s", alu_ops[o].name()), UNIT_ALU,
                            alu_code(alu_ops[o]), 1'b0, alu_a[k], alu_b[k], ~alu_b[k],
                            32'h0000_4000);
                drive_issue($sformatf("alu_imm_%s", alu_ops[o].name()), UNIT_ALU,
                            alu_code(alu_ops[o]), 1'b1, alu_a[k], ~alu_b[k], alu_b[k],
                            32'h0000_4004);
            end
        end

        // Random issue stream with short gaps
        for (int k = 0; k < 500; k++) begin
            rnd = next_rand();
            if (rnd[7:6] == 2'b00) begin
                repeat (int'(rnd[9:8])) drive_idle("random_gap");
            end
            rnd = next_rand();
            a   = next_rand();
            drive_issue("random",
                        rnd[3:0] < 4'd7 ? UNIT_ALU :
                        rnd[3:0] < 4'd14 ? UNIT_BRANCH :
                        unit_sel_t'(rnd[3:0] == 4'd14 ? 2'b10 : 2'b11),
                        alu_code(alu_op_t'(rnd[7:4])), rnd[8], a,
                        rnd[9] ? a : next_rand(),
                        rnd[10] ? next_rand() : next_rand() & 32'h0000_0ffc,
                        next_rand() & 32'hffff_fffc);
        end
        drive_idle("drain");

        // Let the last results come out
        n = 0;
        while ((exp_q.size() != 0 || have_pend) && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (n_checked == n_pushed && exp_q.size() == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Only %0d of %0d results were checked", n_checked, n_pushed);
            $display("Testbench failed");
            $fatal(1, "results missing");
        end
    end

endmodule

/* files.f */
+incdir+common
common/secv_isa_pkg.sv
common/secv_funit_pkg.sv
common/funit_if.sv
hw/funit/branch_unit.sv
hw/funit/alu_unit.sv
hw/exec_stage.sv
hw/secv_exec_top.sv
verification/tb_secv_exec.sv

/* Makefile */
# Verilator build and run for the execute stage testbench

VERILATOR  ?= verilator
FILELIST   ?= files.f
TB_TOP     ?= tb_secv_exec
RTL_TOP    ?= secv_exec_top
BUILD_DIR  ?= obj_dir
JOBS       ?= 0
VFLAGS     ?= --binary -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing
PASS_MSG   ?= Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

# Pass only when the pass message shows up in the output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)
